//--- video_macros.svh
/*
 * Video macros: mode geometry, colour widths and draw engine sizing
 * for the 64x48 castle display.
 */
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// horizontal timing, in pixels
`define H_ACTIVE 64
`define H_FRONT 4
`define H_SYNC 8
`define H_BACK 4
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)  // 80

// vertical timing, in lines
`define V_ACTIVE 48
`define V_FRONT 2
`define V_SYNC 2
`define V_BACK 2
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)  // 54

`define CORDW 8         // coordinate bits
`define CIDXW 4         // palette index bits
`define CHANW 4         // bits per colour channel
`define FILL_CREDITS 2  // fill engine queue depth
`define SHAPE_CNT 6     // rectangles in the scene

`endif

//--- display_pkg.sv
/*
 * Display package: coordinate, palette index and RGB colour types.
 */
`include "video_macros.svh"

package display_pkg;

    // unsigned screen coordinate
    typedef logic [`CORDW-1:0] coord_t;

    // framebuffer palette index
    typedef logic [`CIDXW-1:0] cidx_t;

    // 12-bit output colour
    typedef struct packed {
        logic [`CHANW-1:0] r;
        logic [`CHANW-1:0] g;
        logic [`CHANW-1:0] b;
    } rgb_t;

endpackage

//--- draw_pkg.sv
/*
 * Drawing package: sequencer and fill engine state encodings
 * and the shape opcode carried on the command channel.
 */
package draw_pkg;

    // scene sequencer states
    typedef enum logic [1:0] {
        WAIT_FRAME,  // hold until framebuffer ready and frame start
        ISSUE,       // send table entries while credits last
        DRAIN,       // wait for every credit to come back
        DONE
    } seq_state_t;

    // fill engine states
    typedef enum logic {
        IDLE,
        FILL
    } fill_state_t;

    // command opcode
    typedef enum logic {
        OP_RECT,  // filled rectangle
        OP_NOP    // empty slot, retired without drawing
    } shape_op_t;

endpackage

//--- display_timings.sv
/*
 * Display timings: raster counters for the 64x48 mode with
 * registered syncs, data enable and frame start pulse.
 */
`timescale 1ns/10ps
`include "video_macros.svh"

module display_timings (
    input  logic                clk_pix,
    input  logic                rst_n,
    output display_pkg::coord_t sx,
    output display_pkg::coord_t sy,
    output logic                hsync,
    output logic                vsync,
    output logic                de,
    output logic                frame
);

    localparam int HS_START = `H_ACTIVE + `H_FRONT;
    localparam int HS_END   = HS_START + `H_SYNC - 1;
    localparam int VS_START = `V_ACTIVE + `V_FRONT;
    localparam int VS_END   = VS_START + `V_SYNC - 1;

    display_pkg::coord_t x_nxt;
    display_pkg::coord_t y_nxt;

    // next raster position
    always_comb begin
        x_nxt = sx + 1'b1;
        y_nxt = sy;
        if (sx == `H_TOTAL - 1) begin
            x_nxt = '0;
            y_nxt = (sy == `V_TOTAL - 1) ? '0 : sy + 1'b1;
        end
    end

    // decode from the next position so flags line up with sx/sy
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sx    <= '0;
            sy    <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b1;  // (0,0) is active
            frame <= 1'b0;  // no frame start out of reset
        end else begin
            sx    <= x_nxt;
            sy    <= y_nxt;
            hsync <= !(x_nxt >= HS_START && x_nxt <= HS_END);  // active low
            vsync <= !(y_nxt >= VS_START && y_nxt <= VS_END);
            de    <= (x_nxt < `H_ACTIVE) && (y_nxt < `V_ACTIVE);
            frame <= (x_nxt == 0) && (y_nxt == 0);
        end
    end

endmodule

//--- framebuffer.sv
/*
 * Framebuffer: 64x48 palette index memory, cleared after reset,
 * with one write port and a registered raster read port.
 */
`timescale 1ns/10ps
`include "video_macros.svh"

module framebuffer (
    input  logic                clk_pix,
    input  logic                rst_n,
    input  logic                wr_en,
    input  display_pkg::coord_t wr_x,
    input  display_pkg::coord_t wr_y,
    input  display_pkg::cidx_t  wr_cidx,
    input  display_pkg::coord_t rd_x,
    input  display_pkg::coord_t rd_y,
    output display_pkg::cidx_t  rd_cidx,
    output logic                ready
);

    localparam int DEPTH = `H_ACTIVE * `V_ACTIVE;  // 3072
    localparam int AW    = $clog2(DEPTH);

    display_pkg::cidx_t mem [DEPTH];
    logic [AW-1:0]      clr_addr;
    logic [AW-1:0]      wr_addr;
    logic [AW-1:0]      rd_addr;
    logic [AW-1:0]      mem_addr;
    logic               mem_we;
    logic               rd_hit;
    display_pkg::cidx_t mem_data;

    // linear address y*64+x
    assign wr_addr = AW'(wr_y) * AW'(`H_ACTIVE) + AW'(wr_x);
    assign rd_addr = AW'(rd_y) * AW'(`H_ACTIVE) + AW'(rd_x);
    assign rd_hit  = (rd_x < `H_ACTIVE) && (rd_y < `V_ACTIVE);

    // clear sweep owns the write port until ready
    assign mem_we   = !ready || wr_en;
    assign mem_addr = ready ? wr_addr : clr_addr;
    assign mem_data = ready ? wr_cidx : '0;

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            clr_addr <= '0;
            ready    <= 1'b0;
        end else if (!ready) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == AW'(DEPTH - 1)) begin
                ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_data;
        end
    end

    // blanking and uncleared cells read as background
    always_ff @(posedge clk_pix) begin
        rd_cidx <= (ready && rd_hit) ? mem[rd_addr] : '0;
    end

endmodule

//--- rect_fill.sv
/*
 * Rectangle fill engine: small command queue feeding a raster
 * walker that writes one pixel per cycle and returns credits.
 */
`timescale 1ns/10ps
`include "video_macros.svh"

module rect_fill (
    input  logic                clk_pix,
    input  logic                rst_n,
    input  logic                cmd_valid,
    input  draw_pkg::shape_op_t cmd_op,
    input  display_pkg::coord_t cmd_x0,
    input  display_pkg::coord_t cmd_y0,
    input  display_pkg::coord_t cmd_x1,
    input  display_pkg::coord_t cmd_y1,
    input  display_pkg::cidx_t  cmd_cidx,
    output logic                wr_en,
    output display_pkg::coord_t wr_x,
    output display_pkg::coord_t wr_y,
    output display_pkg::cidx_t  wr_cidx,
    output logic                credit_return
);

    localparam int DEPTH = `FILL_CREDITS;
    localparam int PW    = $clog2(DEPTH);

    typedef struct packed {
        draw_pkg::shape_op_t op;
        display_pkg::coord_t x0;
        display_pkg::coord_t y0;
        display_pkg::coord_t x1;
        display_pkg::coord_t y1;
        display_pkg::cidx_t  cidx;
    } cmd_t;

    cmd_t                  q_mem [DEPTH];
    logic [PW-1:0]         q_wr;
    logic [PW-1:0]         q_rd;
    logic [PW:0]           q_cnt;
    cmd_t                  in_cmd;
    cmd_t                  head;
    logic                  q_empty;
    logic                  start;
    logic                  push;
    logic                  pop;
    logic                  last_col;
    logic                  last_px;
    draw_pkg::fill_state_t state;
    display_pkg::coord_t   x0;
    display_pkg::coord_t   x1;
    display_pkg::coord_t   y1;

    assign in_cmd  = '{cmd_op, cmd_x0, cmd_y0, cmd_x1, cmd_y1, cmd_cidx};
    assign q_empty = (q_cnt == '0);
    assign head    = q_empty ? in_cmd : q_mem[q_rd];  // empty queue bypass
    assign start   = (state == draw_pkg::IDLE) && (!q_empty || cmd_valid);
    assign pop     = start && !q_empty;
    assign push    = cmd_valid && !(start && q_empty);

    assign last_col = (wr_x == x1);
    assign last_px  = last_col && (wr_y == y1);
    assign wr_en    = (state == draw_pkg::FILL);

    always_ff @(posedge clk_pix) begin
        if (push) begin
            q_mem[q_wr] <= in_cmd;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            q_wr  <= '0;
            q_rd  <= '0;
            q_cnt <= '0;
        end else begin
            if (push) begin
                q_wr <= (q_wr == PW'(DEPTH - 1)) ? '0 : q_wr + 1'b1;
            end
            if (pop) begin
                q_rd <= (q_rd == PW'(DEPTH - 1)) ? '0 : q_rd + 1'b1;
            end
            q_cnt <= q_cnt + (PW+1)'(push) - (PW+1)'(pop);
        end
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            state         <= draw_pkg::IDLE;
            credit_return <= 1'b0;
        end else begin
            credit_return <= 1'b0;
            case (state)
                draw_pkg::IDLE: begin
                    if (start && head.op == draw_pkg::OP_RECT) begin
                        state <= draw_pkg::FILL;
                    end else if (start) begin
                        credit_return <= 1'b1;  // nop retires at once
                    end
                end
                default: begin
                    if (last_px) begin
                        state         <= draw_pkg::IDLE;
                        credit_return <= 1'b1;
                    end
                end
            endcase
        end
    end

    // walker position and rectangle bounds
    always_ff @(posedge clk_pix) begin
        if (state == draw_pkg::IDLE) begin
            if (start) begin
                wr_x    <= head.x0;
                wr_y    <= head.y0;
                x0      <= head.x0;
                x1      <= head.x1;
                y1      <= head.y1;
                wr_cidx <= head.cidx;
            end
        end else if (last_col) begin
            wr_x <= x0;  // next row
            wr_y <= wr_y + 1'b1;
        end else begin
            wr_x <= wr_x + 1'b1;
        end
    end

endmodule

//--- scene_sequencer.sv
/*
 * Scene sequencer: steps through the castle rectangle table and
 * issues one fill command per entry under credit flow control.
 */
`timescale 1ns/10ps
`include "video_macros.svh"

module scene_sequencer (
    input  logic                clk_pix,
    input  logic                rst_n,
    input  logic                frame,
    input  logic                fb_ready,
    input  logic                credit_return,
    output logic                cmd_valid,
    output draw_pkg::shape_op_t cmd_op,
    output display_pkg::coord_t cmd_x0,
    output display_pkg::coord_t cmd_y0,
    output display_pkg::coord_t cmd_x1,
    output display_pkg::coord_t cmd_y1,
    output display_pkg::cidx_t  cmd_cidx,
    output logic                scene_done
);

    localparam int CW = $clog2(`FILL_CREDITS + 1);
    localparam int SW = $clog2(`SHAPE_CNT);

    typedef struct packed {
        display_pkg::coord_t x0;
        display_pkg::coord_t y0;
        display_pkg::coord_t x1;
        display_pkg::coord_t y1;
        display_pkg::cidx_t  cidx;
    } rect_t;

    // later entries paint over earlier ones
    localparam rect_t SCENE [`SHAPE_CNT] = '{
        '{8, 20, 55, 40, 5},   // building
        '{4, 10, 12, 40, 5},   // left tower
        '{51, 10, 59, 40, 5},  // right tower
        '{26, 30, 37, 40, 4},  // door
        '{24, 6, 39, 20, 2},   // middle tower
        '{29, 10, 34, 16, 1}   // window
    };

    draw_pkg::seq_state_t state;
    logic [CW-1:0]        credits;
    logic [CW-1:0]        avail;
    logic [SW-1:0]        shape_id;
    logic                 in_table;
    logic                 issue;
    rect_t                entry;

    assign in_table = (shape_id < `SHAPE_CNT);
    assign entry    = in_table ? SCENE[shape_id] : '0;
    assign avail    = credits - CW'(cmd_valid);  // credit is spent as cmd_valid drops
    assign issue    = (state == draw_pkg::ISSUE) && (avail != '0);

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            state      <= draw_pkg::WAIT_FRAME;
            credits    <= CW'(`FILL_CREDITS);
            shape_id   <= '0;
            cmd_valid  <= 1'b0;
            scene_done <= 1'b0;
        end else begin
            cmd_valid <= issue;
            credits   <= credits - CW'(cmd_valid) + CW'(credit_return);
            case (state)
                draw_pkg::WAIT_FRAME: begin
                    if (frame && fb_ready) begin
                        state <= draw_pkg::ISSUE;
                    end
                end
                draw_pkg::ISSUE: begin
                    if (issue) begin
                        shape_id <= shape_id + 1'b1;
                        if (shape_id == SW'(`SHAPE_CNT - 1)) begin
                            state <= draw_pkg::DRAIN;
                        end
                    end
                end
                draw_pkg::DRAIN: begin
                    if (!cmd_valid && credits == CW'(`FILL_CREDITS)) begin
                        state      <= draw_pkg::DONE;
                        scene_done <= 1'b1;
                    end
                end
                default: state <= draw_pkg::DONE;  // done holds until reset
            endcase
        end
    end

    // command payload
    always_ff @(posedge clk_pix) begin
        if (issue) begin
            cmd_op   <= in_table ? draw_pkg::OP_RECT : draw_pkg::OP_NOP;
            cmd_x0   <= entry.x0;
            cmd_y0   <= entry.y0;
            cmd_x1   <= entry.x1;
            cmd_y1   <= entry.y1;
            cmd_cidx <= entry.cidx;
        end
    end

endmodule

//--- colour_mixer.sv
/*
 * Colour mixer: palette lookup over banded background, with syncs
 * and enable delayed to match the framebuffer read.
 */
`timescale 1ns/10ps

module colour_mixer (
    input  logic                clk_pix,
    input  logic                rst_n,
    input  display_pkg::coord_t sy,
    input  logic                de,
    input  logic                hsync,
    input  logic                vsync,
    input  display_pkg::cidx_t  pix_cidx,
    output display_pkg::rgb_t   rgb,
    output logic                de_out,
    output logic                hsync_out,
    output logic                vsync_out
);

    localparam int BAND_MID = 16;  // first row of middle band
    localparam int BAND_LOW = 32;

    display_pkg::coord_t sy_d;
    logic                de_d;
    logic                hsync_d;
    logic                vsync_d;
    display_pkg::rgb_t   pal_colr;
    display_pkg::rgb_t   bg_colr;

    always_comb begin
        case (pix_cidx)
            1:       pal_colr = 12'h11A;  // dark blue
            2:       pal_colr = 12'h626;  // dark purple
            4:       pal_colr = 12'h852;  // brown
            5:       pal_colr = 12'h555;  // dark grey
            default: pal_colr = 12'hFFF;
        endcase
    end

    always_comb begin
        if (sy_d < BAND_MID) begin
            bg_colr = 12'h239;
        end else if (sy_d < BAND_LOW) begin
            bg_colr = 12'h26C;
        end else begin
            bg_colr = 12'h260;  // ground
        end
    end

    // match framebuffer read latency
    always_ff @(posedge clk_pix) begin
        sy_d <= sy;
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            de_d      <= 1'b0;
            hsync_d   <= 1'b1;
            vsync_d   <= 1'b1;
            de_out    <= 1'b0;
            hsync_out <= 1'b1;
            vsync_out <= 1'b1;
            rgb       <= '0;
        end else begin
            de_d      <= de;
            hsync_d   <= hsync;
            vsync_d   <= vsync;
            de_out    <= de_d;
            hsync_out <= hsync_d;
            vsync_out <= vsync_d;
            if (!de_d) begin
                rgb <= '0;  // black in blanking
            end else begin
                rgb <= (pix_cidx == '0) ? bg_colr : pal_colr;
            end
        end
    end

endmodule

//--- castle_top.sv
/*
 * Castle display top: timing, framebuffer, fill engine, scene
 * sequencer and colour mixer on the pixel clock.
 */
`timescale 1ns/10ps

module castle_top (
    input  logic              clk_pix,
    input  logic              rst_n,
    output display_pkg::rgb_t rgb,
    output logic              de_out,
    output logic              hsync_out,
    output logic              vsync_out,
    output logic              scene_done
);

    display_pkg::coord_t sx;
    display_pkg::coord_t sy;
    logic                hsync;
    logic                vsync;
    logic                de;
    logic                frame;

    logic                fb_ready;
    display_pkg::cidx_t  pix_cidx;

    // command channel
    logic                cmd_valid;
    draw_pkg::shape_op_t cmd_op;
    display_pkg::coord_t cmd_x0;
    display_pkg::coord_t cmd_y0;
    display_pkg::coord_t cmd_x1;
    display_pkg::coord_t cmd_y1;
    display_pkg::cidx_t  cmd_cidx;
    logic                credit_return;

    // pixel write channel
    logic                wr_en;
    display_pkg::coord_t wr_x;
    display_pkg::coord_t wr_y;
    display_pkg::cidx_t  wr_cidx;

    display_timings timings_inst (
        .clk_pix, .rst_n, .sx, .sy, .hsync, .vsync, .de, .frame
    );

    framebuffer fb_inst (
        .clk_pix, .rst_n, .wr_en, .wr_x, .wr_y, .wr_cidx,
        .rd_x(sx), .rd_y(sy), .rd_cidx(pix_cidx), .ready(fb_ready)
    );

    rect_fill fill_inst (
        .clk_pix, .rst_n, .cmd_valid, .cmd_op, .cmd_x0, .cmd_y0, .cmd_x1, .cmd_y1,
        .cmd_cidx, .wr_en, .wr_x, .wr_y, .wr_cidx, .credit_return
    );

    scene_sequencer seq_inst (
        .clk_pix, .rst_n, .frame, .fb_ready, .credit_return, .cmd_valid, .cmd_op,
        .cmd_x0, .cmd_y0, .cmd_x1, .cmd_y1, .cmd_cidx, .scene_done
    );

    colour_mixer mixer_inst (
        .clk_pix, .rst_n, .sy, .de, .hsync, .vsync, .pix_cidx,
        .rgb, .de_out, .hsync_out, .vsync_out
    );

endmodule

//--- castle_properties.sv
/*
 * Castle properties: bound checks on command credits, pixel write
 * addresses and the sync/enable relation at the video output.
 */
`timescale 1ns/10ps
`include "video_macros.svh"

module castle_properties (
    input logic                clk_pix,
    input logic                rst_n,
    input logic                cmd_valid,
    input logic                credit_return,
    input logic                wr_en,
    input display_pkg::coord_t wr_x,
    input display_pkg::coord_t wr_y,
    input logic                de_out,
    input logic                hsync_out
);

    logic [3:0] credits;  // shadow of the sequencer's credit count

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            credits <= 4'(`FILL_CREDITS);
        end else begin
            credits <= credits - 4'(cmd_valid) + 4'(credit_return);
        end
    end

    credit_limit: assert property (@(posedge clk_pix) disable iff (!rst_n)
        credits <= 4'(`FILL_CREDITS))
        else $error("credit count %0d above queue depth", credits);

    credit_spend: assert property (@(posedge clk_pix) disable iff (!rst_n)
        cmd_valid |-> credits != 4'd0)
        else $error("command issued with no credit left");

    write_bounds: assert property (@(posedge clk_pix) disable iff (!rst_n)
        wr_en |-> (wr_x < `H_ACTIVE) && (wr_y < `V_ACTIVE))
        else $error("pixel write outside the frame at (%0d,%0d)", wr_x, wr_y);

    enable_in_sync: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !(de_out && !hsync_out))
        else $error("data enable high during horizontal sync");

endmodule

//--- tb_castle.sv
/*
 * Testbench for the castle display: reset state, raster structure,
 * scene completion and the colours of one captured frame.
 */
`timescale 1ns/10ps
`include "video_macros.svh"

module tb_castle;

    localparam int FRAME_CYC = `H_TOTAL * `V_TOTAL;
    localparam int TIMEOUT   = 4 * FRAME_CYC + 2720;  // 20000 cycles

    logic              clk_pix;
    logic              rst_n;
    display_pkg::rgb_t rgb;
    logic              de_out;
    logic              hsync_out;
    logic              vsync_out;
    logic              scene_done;

    logic [11:0] shot [`H_ACTIVE * `V_ACTIVE];  // captured active frame
    string       smp_name [$];
    int          smp_x [$];
    int          smp_y [$];
    logic [11:0] smp_rgb [$];
    int          errors;
    int          checks;
    int          cycles = 0;
    int          low_cnt;
    int          period;
    int          px;
    int          py;
    int          idx;
    bit          done_lost;

    castle_top uut (
        .clk_pix, .rst_n, .rgb, .de_out, .hsync_out, .vsync_out, .scene_done
    );

    bind castle_top castle_properties props_inst (
        .clk_pix, .rst_n, .cmd_valid, .credit_return, .wr_en, .wr_x, .wr_y,
        .de_out, .hsync_out
    );

    initial clk_pix = 1'b0;
    always #5 clk_pix = ~clk_pix;  // 10 ns period

    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [11:0] band_rgb(input int y);
        if (y < 16) begin
            return 12'h239;
        end else if (y < 32) begin
            return 12'h26C;
        end
        return 12'h260;
    endfunction

    task automatic add_sample(input string name, input int x, input int y,
                              input logic [11:0] exp);
        smp_name.push_back(name);
        smp_x.push_back(x);
        smp_y.push_back(y);
        smp_rgb.push_back(exp);
    endtask

    task automatic compare_rgb(input string name, input logic [11:0] exp,
                               input logic [11:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s expected %03h, got %03h", name, exp, act);
        end
    endtask

    task automatic verify_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("Error: %s expected %0d, got %0d", name, exp, act);
        end
    endtask

    task automatic check_idle(input string when);
        checks++;
        if (de_out !== 1'b0 || hsync_out !== 1'b1 || vsync_out !== 1'b1 || rgb !== '0) begin
            errors++;
            $display("Error: %s expected de/hs/vs/rgb 0/1/1/000, got %b/%b/%b/%03h",
                     when, de_out, hsync_out, vsync_out, rgb);
        end
    endtask

    // points picked from the scene list, palette and bands
    task automatic fill_table();
        add_sample("window centre", 31, 13, 12'h11A);
        add_sample("window top left", 29, 10, 12'h11A);
        add_sample("window bottom right", 34, 16, 12'h11A);
        add_sample("tower left of window", 28, 13, 12'h626);
        add_sample("tower right of window", 35, 16, 12'h626);
        add_sample("middle tower corner", 24, 6, 12'h626);
        add_sample("sky above tower", 24, 5, 12'h239);
        add_sample("tower over building", 30, 20, 12'h626);
        add_sample("tower edge row 19", 39, 19, 12'h626);
        add_sample("building past tower", 40, 20, 12'h555);
        add_sample("building below tower", 30, 21, 12'h555);
        add_sample("door top left", 26, 30, 12'h852);
        add_sample("door bottom right", 37, 40, 12'h852);
        add_sample("wall beside door", 25, 35, 12'h555);
        add_sample("ground below door", 31, 41, 12'h260);
        add_sample("left tower top", 4, 10, 12'h555);
        add_sample("sky over left tower", 4, 9, 12'h239);
        add_sample("left tower on building", 10, 30, 12'h555);
        add_sample("right tower corner", 59, 40, 12'h555);
        add_sample("ground right of tower", 60, 40, 12'h260);
        add_sample("roof gap upper band", 18, 15, 12'h239);
        add_sample("roof gap middle band", 18, 16, 12'h26C);
        add_sample("roof gap above wall", 45, 19, 12'h26C);
        add_sample("wall under roof gap", 18, 20, 12'h555);
        add_sample("sky band edge 31", 62, 31, 12'h26C);
        add_sample("ground band edge 32", 0, 32, 12'h260);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        rst_n  = 1'b0;
        fill_table();

        for (idx = 0; idx < 3; idx++) begin
            @(posedge clk_pix);
            if (idx == 2) begin
                rst_n <= 1'b1;  // seen on the next edge
            end
            @(negedge clk_pix);
            check_idle("during reset");
        end
        @(negedge clk_pix);
        check_idle("first cycle after reset");

        // one hsync_out pulse and its period
        while (hsync_out !== 1'b1) @(negedge clk_pix);
        while (hsync_out === 1'b1) @(negedge clk_pix);
        low_cnt = 0;
        while (hsync_out === 1'b0) begin
            low_cnt++;
            @(negedge clk_pix);
        end
        period = low_cnt;
        while (hsync_out === 1'b1) begin
            period++;
            @(negedge clk_pix);
        end
        verify_count("hsync_out low cycles", `H_SYNC, low_cnt);
        verify_count("hsync_out period", `H_TOTAL, period);

        while (scene_done !== 1'b1) @(negedge clk_pix);
        while (vsync_out !== 1'b0) @(negedge clk_pix);
        while (vsync_out !== 1'b1) @(negedge clk_pix);

        // capture the frame that follows the vsync rising edge
        px = 0;
        py = 0;
        done_lost = 1'b0;
        while (vsync_out === 1'b1) begin
            if (scene_done !== 1'b1) begin
                done_lost = 1'b1;
            end
            if (de_out === 1'b1) begin
                if (px < `H_ACTIVE && py < `V_ACTIVE) begin
                    shot[py * `H_ACTIVE + px] = rgb;
                end
                px++;
            end else if (px != 0) begin
                verify_count($sformatf("de_out cycles on line %0d", py), `H_ACTIVE, px);
                py++;
                px = 0;
            end
            @(negedge clk_pix);
        end
        verify_count("active lines per frame", `V_ACTIVE, py);
        checks++;
        if (done_lost) begin
            errors++;
            $display("scene_done fell after it had risen");
        end

        for (idx = 0; idx < smp_name.size(); idx++) begin
            compare_rgb(smp_name[idx], smp_rgb[idx],
                        shot[smp_y[idx] * `H_ACTIVE + smp_x[idx]]);
        end

        // columns 0-3 and 60-63 lie outside every rectangle
        for (py = 0; py < `V_ACTIVE; py++) begin
            for (idx = 0; idx < 8; idx++) begin
                px = (idx < 4) ? idx : `H_ACTIVE - 8 + idx;
                compare_rgb($sformatf("background (%0d,%0d)", px, py), band_rgb(py),
                            shot[py * `H_ACTIVE + px]);
            end
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+.
display_pkg.sv
draw_pkg.sv
display_timings.sv
framebuffer.sv
rect_fill.sv
scene_sequencer.sv
colour_mixer.sv
castle_top.sv
castle_properties.sv
tb_castle.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_castle
FILELIST  = all.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
